//--- design/CpuPkg.sv
package CpuPkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    localparam int WordWidth = 32;
    localparam int RegCount  = 16;
    localparam int StepWidth = 3;
    localparam int AddrWidth = 15;

    typedef logic [$clog2(RegCount)-1:0] RegIndex;

    // ------------------------------------------------------------------------
    // Instruction format and control encodings
    // ------------------------------------------------------------------------
    typedef enum logic [4:0] {
        OpLoad = 5'd0,
        OpAdd  = 5'd1,
        OpSub  = 5'd2,
        OpAnd  = 5'd3,
        OpOr   = 5'd4,
        OpNot  = 5'd5,
        OpNeg  = 5'd6,
        OpMul  = 5'd7,
        OpMfhi = 5'd8,
        OpMflo = 5'd9,
        OpHalt = 5'd10
    } OpCode;

    typedef struct packed {
        OpCode                opcode;  // Bits 31..27.
        RegIndex              ra;      // Destination.
        RegIndex              rb;
        RegIndex              rc;
        logic [AddrWidth-1:0] address; // Zero-extended onto the bus.
    } InstrFields;

    typedef enum logic [3:0] {
        SrcNone,
        SrcReg,
        SrcPc,
        SrcMdr,
        SrcZLow,
        SrcZHigh,
        SrcHi,
        SrcLo,
        SrcAddr
    } BusSource;

    typedef enum logic [1:0] {
        StFetch,
        StExecute,
        StHalted
    } CpuState;

    typedef struct packed {
        BusSource busSource;
        RegIndex  regSelect;
        logic     regIn;
        logic     pcIn;
        logic     incPc;     // Z gets bus + 1 and Y clears.
        logic     marIn;
        logic     mdrIn;
        logic     irIn;
        logic     read;
        logic     yIn;
        logic     zIn;
        logic     hiIn;
        logic     loIn;
        OpCode    aluOp;
    } ControlWord;

endpackage

//--- design/StepCounter.sv
`timescale 1ns/1ps

module StepCounter (
    input  logic                           Clock,
    input  logic                           rst,
    input  logic                           stepClear,
    output logic [CpuPkg::StepWidth-1:0]   step
);

    // Next step is zero after a phase ends.
    always_ff @(posedge Clock) begin
        if (rst || stepClear) begin
            step <= '0;
        end else begin
            step <= step + 1'b1;
        end
    end

endmodule

//--- design/ControlUnit.sv
`timescale 1ns/1ps

module ControlUnit (
    input  logic                         Clock,
    input  logic                         rst,
    input  logic [CpuPkg::StepWidth-1:0] step,
    input  CpuPkg::InstrFields           instr,
    output CpuPkg::ControlWord           control,
    output logic                         stepClear,
    output logic                         instrDone,
    output logic                         halted
);

    CpuPkg::CpuState state;
    CpuPkg::CpuState nextState;
    logic            lastStep;

    always_ff @(posedge Clock) begin
        if (rst) begin
            state <= CpuPkg::StFetch;
        end else begin
            state <= nextState;
        end
    end

    assign halted = (state == CpuPkg::StHalted);

    // ------------------------------------------------------------------------
    // Micro-step decode
    // ------------------------------------------------------------------------
    always_comb begin
        control   = '0;
        nextState = state;
        lastStep  = 1'b0;
        stepClear = 1'b0;
        instrDone = 1'b0;
        case (state)
            CpuPkg::StFetch: begin
                case (step)
                    3'd0: begin
                        control.busSource = CpuPkg::SrcPc;
                        control.marIn     = 1'b1;
                        control.incPc     = 1'b1;
                        control.zIn       = 1'b1;
                    end
                    3'd1: begin
                        control.busSource = CpuPkg::SrcZLow;
                        control.pcIn      = 1'b1;
                        control.read      = 1'b1;
                        control.mdrIn     = 1'b1;
                    end
                    default: begin
                        control.busSource = CpuPkg::SrcMdr;
                        control.irIn      = 1'b1;
                        stepClear         = 1'b1;
                        nextState         = CpuPkg::StExecute;
                    end
                endcase
            end
            CpuPkg::StExecute: begin
                case (instr.opcode)
                    CpuPkg::OpLoad: begin
                        case (step)
                            3'd0: begin
                                control.busSource = CpuPkg::SrcAddr;
                                control.marIn     = 1'b1;
                            end
                            3'd1: begin
                                control.read  = 1'b1;
                                control.mdrIn = 1'b1;
                            end
                            default: begin
                                control.busSource = CpuPkg::SrcMdr;
                                control.regSelect = instr.ra;
                                control.regIn     = 1'b1;
                                lastStep          = 1'b1;
                            end
                        endcase
                    end
                    CpuPkg::OpAdd, CpuPkg::OpSub, CpuPkg::OpAnd, CpuPkg::OpOr,
                    CpuPkg::OpNot, CpuPkg::OpNeg, CpuPkg::OpMul: begin
                        case (step)
                            3'd0: begin
                                control.busSource = CpuPkg::SrcReg;
                                control.regSelect = instr.rb;
                                control.yIn       = 1'b1;
                            end
                            3'd1: begin
                                control.busSource = CpuPkg::SrcReg;
                                control.regSelect = instr.rc;
                                control.aluOp     = instr.opcode;
                                control.zIn       = 1'b1;
                            end
                            3'd2: begin
                                control.busSource = CpuPkg::SrcZLow;
                                if (instr.opcode == CpuPkg::OpMul) begin
                                    control.loIn = 1'b1;
                                end else begin
                                    control.regSelect = instr.ra;
                                    control.regIn     = 1'b1;
                                    lastStep          = 1'b1;
                                end
                            end
                            default: begin
                                control.busSource = CpuPkg::SrcZHigh; // Mul only.
                                control.hiIn      = 1'b1;
                                lastStep          = 1'b1;
                            end
                        endcase
                    end
                    CpuPkg::OpMfhi, CpuPkg::OpMflo: begin
                        control.busSource = (instr.opcode == CpuPkg::OpMfhi) ?
                                            CpuPkg::SrcHi : CpuPkg::SrcLo;
                        control.regSelect = instr.ra;
                        control.regIn     = 1'b1;
                        lastStep          = 1'b1;
                    end
                    default: begin
                        stepClear = 1'b1; // Halt and unknown codes.
                        nextState = CpuPkg::StHalted;
                    end
                endcase
                if (lastStep) begin
                    stepClear = 1'b1;
                    instrDone = 1'b1;
                    nextState = CpuPkg::StFetch;
                end
            end
            default: begin
                stepClear = 1'b1; // Parked until rst.
            end
        endcase
    end

endmodule

//--- design/RegisterFile.sv
`timescale 1ns/1ps

module RegisterFile (
    input  logic                         Clock,
    input  logic                         rst,
    input  CpuPkg::ControlWord           control,
    input  logic [CpuPkg::WordWidth-1:0] bus,
    output logic [CpuPkg::WordWidth-1:0] regData
);

    logic [CpuPkg::WordWidth-1:0] regs [CpuPkg::RegCount];

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < CpuPkg::RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (control.regIn) begin
            regs[control.regSelect] <= bus;
        end
    end

    assign regData = regs[control.regSelect]; // Same select for read and write.

endmodule

//--- design/FetchRegisters.sv
`timescale 1ns/1ps

module FetchRegisters (
    input  logic                         Clock,
    input  logic                         rst,
    input  CpuPkg::ControlWord           control,
    input  logic [CpuPkg::WordWidth-1:0] bus,
    input  logic [CpuPkg::WordWidth-1:0] memData,
    output logic [CpuPkg::WordWidth-1:0] pcData,
    output logic [CpuPkg::WordWidth-1:0] mdrData,
    output logic [CpuPkg::WordWidth-1:0] memAddr,
    output CpuPkg::InstrFields           instr
);

    always_ff @(posedge Clock) begin
        if (rst) begin
            pcData  <= '0;
            memAddr <= '0;
        end else begin
            if (control.pcIn) begin
                pcData <= bus;
            end
            if (control.marIn) begin
                memAddr <= bus; // MAR drives the memory address directly.
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (control.mdrIn) begin
            mdrData <= control.read ? memData : bus;
        end
        if (control.irIn) begin
            instr <= CpuPkg::InstrFields'(bus);
        end
    end

endmodule

//--- design/AluUnit.sv
`timescale 1ns/1ps

module AluUnit (
    input  logic                         Clock,
    input  logic                         rst,
    input  CpuPkg::ControlWord           control,
    input  logic [CpuPkg::WordWidth-1:0] bus,
    output logic [CpuPkg::WordWidth-1:0] zLow,
    output logic [CpuPkg::WordWidth-1:0] zHigh,
    output logic [CpuPkg::WordWidth-1:0] hiData,
    output logic [CpuPkg::WordWidth-1:0] loData
);

    logic        [CpuPkg::WordWidth-1:0]   y;
    logic        [2*CpuPkg::WordWidth-1:0] z;
    logic        [2*CpuPkg::WordWidth-1:0] aluResult;
    logic signed [2*CpuPkg::WordWidth-1:0] product;
    logic        [CpuPkg::WordWidth-1:0]   lowResult;

    // ------------------------------------------------------------------------
    // Operations, Y is the left operand
    // ------------------------------------------------------------------------
    always_comb begin
        product   = $signed(y) * $signed(bus);
        lowResult = '0;
        case (control.aluOp)
            CpuPkg::OpAdd: lowResult = y + bus;
            CpuPkg::OpSub: lowResult = y - bus;
            CpuPkg::OpAnd: lowResult = y & bus;
            CpuPkg::OpOr:  lowResult = y | bus;
            CpuPkg::OpNot: lowResult = ~y;
            CpuPkg::OpNeg: lowResult = -y;
            default:       lowResult = '0;
        endcase
        if (control.aluOp == CpuPkg::OpMul) begin
            aluResult = product;
        end else begin
            aluResult = {{CpuPkg::WordWidth{1'b0}}, lowResult};
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            y      <= '0;
            z      <= '0;
            hiData <= '0;
            loData <= '0;
        end else begin
            if (control.incPc) begin
                y <= '0;
            end else if (control.yIn) begin
                y <= bus;
            end
            if (control.zIn) begin
                z <= control.incPc ? {{CpuPkg::WordWidth{1'b0}}, bus + 1'b1} : aluResult;
            end
            if (control.hiIn) begin
                hiData <= bus;
            end
            if (control.loIn) begin
                loData <= bus;
            end
        end
    end

    assign zLow  = z[CpuPkg::WordWidth-1:0];
    assign zHigh = z[2*CpuPkg::WordWidth-1:CpuPkg::WordWidth];

endmodule

//--- design/BusMux.sv
`timescale 1ns/1ps

module BusMux (
    input  CpuPkg::ControlWord           control,
    input  logic [CpuPkg::WordWidth-1:0] regData,
    input  logic [CpuPkg::WordWidth-1:0] pcData,
    input  logic [CpuPkg::WordWidth-1:0] mdrData,
    input  logic [CpuPkg::WordWidth-1:0] zLow,
    input  logic [CpuPkg::WordWidth-1:0] zHigh,
    input  logic [CpuPkg::WordWidth-1:0] hiData,
    input  logic [CpuPkg::WordWidth-1:0] loData,
    input  CpuPkg::InstrFields           instr,
    output logic [CpuPkg::WordWidth-1:0] bus
);

    always_comb begin
        case (control.busSource)
            CpuPkg::SrcReg:   bus = regData;
            CpuPkg::SrcPc:    bus = pcData;
            CpuPkg::SrcMdr:   bus = mdrData;
            CpuPkg::SrcZLow:  bus = zLow;
            CpuPkg::SrcZHigh: bus = zHigh;
            CpuPkg::SrcHi:    bus = hiData;
            CpuPkg::SrcLo:    bus = loData;
            CpuPkg::SrcAddr:  bus = {{(CpuPkg::WordWidth-CpuPkg::AddrWidth){1'b0}}, instr.address};
            default:          bus = '0; // Idle bus reads as zero.
        endcase
    end

endmodule

//--- design/MiniCpu.sv
`timescale 1ns/1ps

module MiniCpu (
    input  logic                         Clock,
    input  logic                         rst,
    input  logic [CpuPkg::WordWidth-1:0] memData,
    output logic [CpuPkg::WordWidth-1:0] memAddr,
    output logic                         memRead,
    output logic                         instrDone,
    output logic                         halted
);

    CpuPkg::ControlWord           control;
    CpuPkg::InstrFields           instr;
    logic [CpuPkg::StepWidth-1:0] step;
    logic                         stepClear;
    logic [CpuPkg::WordWidth-1:0] bus;
    logic [CpuPkg::WordWidth-1:0] regData;
    logic [CpuPkg::WordWidth-1:0] pcData;
    logic [CpuPkg::WordWidth-1:0] mdrData;
    logic [CpuPkg::WordWidth-1:0] zLow;
    logic [CpuPkg::WordWidth-1:0] zHigh;
    logic [CpuPkg::WordWidth-1:0] hiData;
    logic [CpuPkg::WordWidth-1:0] loData;

    assign memRead = control.read; // Memory answers in the same cycle.

    StepCounter stepCounter (
        .Clock(Clock), .rst(rst), .stepClear(stepClear), .step(step)
    );

    ControlUnit controlUnit (
        .Clock(Clock), .rst(rst), .step(step), .instr(instr), .control(control),
        .stepClear(stepClear), .instrDone(instrDone), .halted(halted)
    );

    RegisterFile registerFile (
        .Clock(Clock), .rst(rst), .control(control), .bus(bus), .regData(regData)
    );

    FetchRegisters fetchRegisters (
        .Clock(Clock), .rst(rst), .control(control), .bus(bus), .memData(memData),
        .pcData(pcData), .mdrData(mdrData), .memAddr(memAddr), .instr(instr)
    );

    AluUnit aluUnit (
        .Clock(Clock), .rst(rst), .control(control), .bus(bus), .zLow(zLow),
        .zHigh(zHigh), .hiData(hiData), .loData(loData)
    );

    BusMux busMux (
        .control(control), .regData(regData), .pcData(pcData), .mdrData(mdrData),
        .zLow(zLow), .zHigh(zHigh), .hiData(hiData), .loData(loData), .instr(instr),
        .bus(bus)
    );

endmodule

//--- bench/MiniCpuTb.sv
`timescale 1ns/1ps

module MiniCpuTb;

    localparam int MemWords   = 64;
    localparam int DataBase   = 40;
    localparam int ProgLength = 13;
    localparam int HaltIndex  = ProgLength - 1; // Last program slot.
    localparam int WaitLimit  = 50;

    logic        Clock = 1'b0;
    logic        rst;
    logic [31:0] memData;
    logic [31:0] memAddr;
    logic        memRead;
    logic        instrDone;
    logic        halted;

    logic [31:0]   mem [MemWords];
    CpuPkg::OpCode progOp [ProgLength];
    logic [14:0]   progAddr [ProgLength];
    logic [31:0]   progExpect [ProgLength];
    logic [31:0]   wordA;
    logic [31:0]   wordB;
    logic [63:0]   product;
    integer        seed;
    int            doneCount;
    int            cycleCount;
    int            readsSeen;
    int            testErrors;
    int            passCount;
    int            failCount;
    bit            timedOut;
    bit            haltSeen;

    MiniCpu DUT (
        .Clock(Clock), .rst(rst), .memData(memData), .memAddr(memAddr),
        .memRead(memRead), .instrDone(instrDone), .halted(halted)
    );

    always #5 Clock = ~Clock;

    assign memData = mem[memAddr[5:0]]; // Answers in the same cycle.

    // -------------------------------------------------------------------------
    // Program and expected values
    // -------------------------------------------------------------------------
    function automatic logic [31:0] encodeInstr(input CpuPkg::OpCode op,
            input logic [3:0] ra, input logic [3:0] rb, input logic [3:0] rc,
            input logic [14:0] addr);
        return {op, ra, rb, rc, addr};
    endfunction

    function automatic int cyclesFor(input CpuPkg::OpCode op);
        case (op)
            CpuPkg::OpMul:                  return 7;
            CpuPkg::OpMfhi, CpuPkg::OpMflo: return 4;
            default:                        return 6; // Three fetch and three execute steps.
        endcase
    endfunction

    task automatic placeInstr(input int idx, input CpuPkg::OpCode op, input logic [3:0] ra,
            input logic [3:0] rb, input logic [3:0] rc, input logic [14:0] addr,
            input logic [31:0] value);
        mem[idx]        = encodeInstr(op, ra, rb, rc, addr);
        progOp[idx]     = op;
        progAddr[idx]   = addr;
        progExpect[idx] = value;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < MemWords; i++) begin
            mem[i] = 32'hC0DE_0000 + i;
        end
        wordA   = $random(seed);
        wordB   = $random(seed);
        product = $signed({{32{wordA[31]}}, wordA}) * $signed({{32{wordB[31]}}, wordB});
        mem[DataBase]     = wordA;
        mem[DataBase + 1] = wordB;
        placeInstr(0, CpuPkg::OpLoad, 4'd1, 4'd0, 4'd0, 15'(DataBase), wordA);
        placeInstr(1, CpuPkg::OpLoad, 4'd2, 4'd0, 4'd0, 15'(DataBase + 1), wordB);
        placeInstr(2, CpuPkg::OpAdd, 4'd3, 4'd1, 4'd2, 15'd0, wordA + wordB);
        placeInstr(3, CpuPkg::OpSub, 4'd4, 4'd1, 4'd2, 15'd0, wordA - wordB);
        placeInstr(4, CpuPkg::OpAnd, 4'd5, 4'd1, 4'd2, 15'd0, wordA & wordB);
        placeInstr(5, CpuPkg::OpOr, 4'd6, 4'd1, 4'd2, 15'd0, wordA | wordB);
        placeInstr(6, CpuPkg::OpNot, 4'd7, 4'd1, 4'd0, 15'd0, ~wordA);
        placeInstr(7, CpuPkg::OpNeg, 4'd8, 4'd2, 4'd0, 15'd0, -wordB);
        placeInstr(8, CpuPkg::OpMul, 4'd0, 4'd1, 4'd2, 15'd0, product[63:32]); // HI on last step.
        placeInstr(9, CpuPkg::OpMfhi, 4'd9, 4'd0, 4'd0, 15'd0, product[63:32]);
        placeInstr(10, CpuPkg::OpMflo, 4'd10, 4'd0, 4'd0, 15'd0, product[31:0]);
        placeInstr(11, CpuPkg::OpAdd, 4'd11, 4'd9, 4'd0, 15'd0, product[63:32]); // R0 is zero.
        placeInstr(12, CpuPkg::OpHalt, 4'd0, 4'd0, 4'd0, 15'd0, 32'd0);
    endtask

    task automatic recordResult(input string name);
        if (testErrors == 0) begin
            passCount++;
            $display("test %s: passed", name);
        end else begin
            failCount++;
            $display("test %s: failed with %0d errors", name, testErrors);
        end
        testErrors = 0;
    endtask

    task automatic waitForDone(input int target);
        int cycles;
        cycles = 0;
        while (doneCount < target && cycles < WaitLimit) begin
            @(posedge Clock);
            cycles++;
        end
        if (doneCount < target) begin
            $display("Timeout: instruction %0d did not finish within %0d cycles",
                     target - 1, WaitLimit);
            timedOut = 1'b1;
        end
    endtask

    task automatic waitForHalted();
        int cycles;
        cycles = 0;
        while (!halted && cycles < WaitLimit) begin
            @(posedge Clock);
            cycles++;
        end
        if (!halted) begin
            $display("Timeout: the CPU did not halt within %0d cycles", WaitLimit);
            timedOut = 1'b1;
        end
    endtask

    // -------------------------------------------------------------------------
    // Monitor sampled on the falling edge
    // -------------------------------------------------------------------------
    always @(negedge Clock) begin : monitor
        CpuPkg::OpCode op;
        if (rst) begin
            cycleCount = 0;
            readsSeen  = 0;
            assert (!memRead && !instrDone && !halted)
            else begin
                $display("A strobe or status output was high during reset");
                testErrors++;
            end
        end else begin
            cycleCount++;
            op = progOp[doneCount];
            if (memRead) begin
                if (readsSeen == 0) begin
                    assert (memAddr == 32'(doneCount)) // Fetch from the PC.
                    else begin
                        $display("FAILED memAddr: expected 0x%h, actual 0x%h",
                                 32'(doneCount), memAddr);
                        testErrors++;
                    end
                end else begin
                    assert (op == CpuPkg::OpLoad && readsSeen == 1)
                    else begin
                        $display("Unexpected memory read during instruction %0d", doneCount);
                        testErrors++;
                    end
                    assert (memAddr == 32'(progAddr[doneCount]))
                    else begin
                        $display("FAILED memAddr: expected 0x%h, actual 0x%h",
                                 32'(progAddr[doneCount]), memAddr);
                        testErrors++;
                    end
                end
                readsSeen++;
            end
            if (instrDone) begin
                if (doneCount < HaltIndex) begin
                    assert (cycleCount == cyclesFor(op))
                    else begin
                        $display("instrDone came after %0d cycles instead of %0d",
                                 cycleCount, cyclesFor(op));
                        testErrors++;
                    end
                    assert (DUT.bus === progExpect[doneCount]) // Value written on last step.
                    else begin
                        $display("FAILED bus: expected 0x%h, actual 0x%h",
                                 progExpect[doneCount], DUT.bus);
                        testErrors++;
                    end
                    recordResult($sformatf("%0d %s", doneCount, op.name()));
                    doneCount++;
                end else begin
                    $display("instrDone pulsed after the Halt instruction was fetched");
                    testErrors++;
                end
                cycleCount = 0;
                readsSeen  = 0;
            end
            if (halted && !haltSeen) begin
                haltSeen = 1'b1;
                assert (doneCount == HaltIndex && cycleCount == 5)
                else begin
                    $display("halted rose at the wrong time (%0d cycles)", cycleCount);
                    testErrors++;
                end
            end
        end
    end

    // -------------------------------------------------------------------------
    // Main sequence
    // -------------------------------------------------------------------------
    initial begin : mainSequence
        rst        = 1'b1;
        seed       = 32'hd3b43a91;
        doneCount  = 0;
        cycleCount = 0;
        readsSeen  = 0;
        testErrors = 0;
        passCount  = 0;
        failCount  = 0;
        timedOut   = 1'b0;
        haltSeen   = 1'b0;
        loadProgram();

        repeat (4) @(posedge Clock);
        rst <= 1'b0;
        recordResult("reset");

        for (int i = 1; i <= HaltIndex && !timedOut; i++) begin
            waitForDone(i);
        end
        if (!timedOut) begin
            waitForHalted();
        end
        if (!timedOut) begin
            repeat (20) begin
                @(negedge Clock);
                assert (halted && !memRead && !instrDone)
                else begin
                    $display("CPU left the halted state or touched memory after Halt");
                    testErrors++;
                end
            end
            @(posedge Clock);
            recordResult("halt");
        end

        $display("tests passed: %0d, tests failed: %0d", passCount, failCount);
        if (failCount == 0 && !timedOut) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- all.f
design/CpuPkg.sv
design/StepCounter.sv
design/ControlUnit.sv
design/RegisterFile.sv
design/FetchRegisters.sv
design/AluUnit.sv
design/BusMux.sv
design/MiniCpu.sv
bench/MiniCpuTb.sv

//--- Bender.yml
package:
  name: mini_cpu

sources:
  - design/CpuPkg.sv
  - design/StepCounter.sv
  - design/ControlUnit.sv
  - design/RegisterFile.sv
  - design/FetchRegisters.sv
  - design/AluUnit.sv
  - design/BusMux.sv
  - design/MiniCpu.sv
  - target: simulation
    files:
      - bench/MiniCpuTb.sv
